/* Makefile */
TOP = tb_spu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

# builds, runs, and passes only if the pass line shows up
sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

/* hdl/line_buffer.sv */
module line_buffer (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            line_start,
	input  logic            wr_en,
	input  logic [8:0]      wr_x,
	input  spu_pkg::color_t wr_pix,
	input  logic            pix_en,
	output logic            pix_valid,
	output spu_pkg::color_t pix_color
);
	spu_pkg::color_t mem [2][spu_pkg::line_w];

	logic sel;		// half being built, display reads the other
	logic [8:0] rd_x;	// display address
	logic [8:0] clr_cnt;	// post-reset clear
	logic clr_act;
	logic wr_ok;
	logic rd_ok;

	assign clr_act = ~clr_cnt[8];
	assign wr_ok = wr_en && (wr_x < 9'(spu_pkg::line_w)) && wr_pix.opaque;	// clip, transparency
	assign rd_ok = pix_en && (rd_x < 9'(spu_pkg::line_w));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel <= 1'b0;
			rd_x <= '0;
			clr_cnt <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			if (clr_act)
				clr_cnt <= clr_cnt + 9'd1;
			if (line_start)
			begin
				sel <= ~sel;	// swap halves
				rd_x <= '0;
			end
			else if (pix_en)
				rd_x <= rd_x + 9'd1;
			pix_valid <= pix_en;
		end
	end

	// --------------------
	// storage
	// --------------------
	always_ff @(posedge clk)
	begin
		if (clr_act)
		begin
			mem[0][clr_cnt[7:0]] <= '0;
			mem[1][clr_cnt[7:0]] <= '0;
		end
		else
		begin
			if (wr_ok)
				mem[sel][wr_x[7:0]] <= wr_pix;
			if (rd_ok)
				mem[~sel][rd_x[7:0]] <= '0;	// clear on read
		end
		if (rd_ok)
			pix_color <= mem[~sel][rd_x[7:0]];
	end

	a_pix_count: assert property (@(posedge clk) disable iff (!arst_n)
		pix_en && !line_start |-> rd_x < 9'(spu_pkg::line_w));

endmodule

/* hdl/sprite_engine.sv */
module sprite_engine #(
	parameter int num_sprites = 16
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           frame_start,
	input  logic                           line_start,
	output logic [$clog2(num_sprites)-1:0] attr_idx,
	input  spu_pkg::sprite_attr_t          attr,
	output logic [7:0]                     pal_addr,
	input  spu_pkg::color_t                pal_data,
	output logic                           mem_req,
	output logic [15:0]                    mem_addr,
	input  logic                           mem_ack,
	input  logic [15:0]                    mem_data,
	output logic                           wr_en,
	output logic [8:0]                     wr_x,
	output spu_pkg::color_t                wr_pix,
	output logic                           busy
);
	localparam int idx_w = $clog2(num_sprites);

	typedef enum logic [2:0] {s_init, s_idle, s_attr, s_check, s_wait, s_pix} state_e;

	state_e state;
	logic [7:0] init_cnt;		// post-reset clear, 256 cycles
	logic [8:0] line_cnt;		// next line to build
	logic [8:0] cur_line;		// line being built
	logic [idx_w-1:0] spr;
	logic [5:0] word_idx;
	logic [2:0] pix;		// pixel within word
	spu_pkg::sprite_attr_t sa;	// latched attributes
	logic [15:0] line_addr;		// first word of the row
	spu_pkg::mem_word_u word;

	// pixel stage, aligned with pal_data
	logic p1_valid;
	logic [8:0] p1_x;
	logic p1_tc;
	spu_pkg::color_t p1_byte;

	logic [9:0] dy;
	logic covers;
	logic [6:0] row;
	logic [1:0] sh;
	logic [2:0] ppw_m1;
	logic [8:0] k;
	logic [8:0] tw;
	logic [9:0] xpos;
	logic [3:0] idx;
	logic last_pix;
	logic last_word;
	logic spr_done;

	// --------------------
	// geometry
	// --------------------
	assign dy = {1'b0, cur_line} - {1'b0, sa.y};	// above the sprite wraps past 511
	assign covers = (sa.mode != spu_pkg::off) && (sa.width_words != 6'd0)
		&& (dy < {3'b0, sa.height});
	assign row = sa.flip_y ? (sa.height - 7'd1 - dy[6:0]) : dy[6:0];
	assign sh = spu_pkg::ppw_log2(sa.mode);
	assign ppw_m1 = 3'((4'd1 << sh) - 4'd1);
	assign k = ({3'b0, word_idx} << sh) + {6'b0, pix};	// pixel number in row
	assign tw = {3'b0, sa.width_words} << sh;		// row width in pixels
	assign xpos = sa.flip_x ? ({1'b0, sa.x} + {1'b0, tw} - 10'd1 - {1'b0, k})
		: ({1'b0, sa.x} + {1'b0, k});

	// decode through the union, msb field first
	assign idx = (sa.mode == spu_pkg::four_color) ? {2'b00, word.c4[~pix]} : word.c16[~pix[1:0]];
	assign pal_addr = {sa.pal, idx};

	assign last_pix = (pix == ppw_m1);
	assign last_word = (word_idx == sa.width_words - 6'd1);
	assign spr_done = ((state == s_check) && !covers)
		|| ((state == s_pix) && last_pix && last_word);

	assign attr_idx = spr;
	assign mem_addr = line_addr + 16'(word_idx);

	// write one cycle after the palette read
	assign wr_en = p1_valid;
	assign wr_x = p1_x;
	assign wr_pix = p1_tc ? p1_byte : pal_data;

	// --------------------
	// control FSM
	// --------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_init;
			init_cnt <= '0;
			line_cnt <= '0;
			cur_line <= '0;
			spr <= '0;
			word_idx <= '0;
			pix <= '0;
			mem_req <= 1'b0;
			p1_valid <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			p1_valid <= 1'b0;
			if (line_start)
			begin
				cur_line <= frame_start ? 9'd0 : line_cnt;		// build this one
				line_cnt <= (frame_start ? 9'd0 : line_cnt) + 9'd1;
			end
			else if (frame_start)
				line_cnt <= '0;

			if (state == s_init)
			begin
				init_cnt <= init_cnt + 8'd1;
				busy <= (init_cnt != 8'hff);	// buffers clearing
				if (init_cnt == 8'hff)
					state <= s_idle;
			end
			else if (line_start)
			begin
				state <= s_attr;	// restart from sprite 0
				spr <= '0;
				mem_req <= 1'b0;
				busy <= 1'b1;
			end
			else
			begin
				case (state)
					s_attr: state <= s_check;
					s_check:
					begin
						if (covers)
						begin
							word_idx <= '0;
							mem_req <= 1'b1;
							state <= s_wait;
						end
					end
					s_wait:
					begin
						if (mem_ack)
						begin
							mem_req <= 1'b0;	// low while decoding
							pix <= '0;
							state <= s_pix;
						end
					end
					s_pix:
					begin
						p1_valid <= ~xpos[9];	// beyond 511 never written
						pix <= pix + 3'd1;
						if (last_pix && !last_word)
						begin
							word_idx <= word_idx + 6'd1;
							mem_req <= 1'b1;
							state <= s_wait;
						end
					end
					default: ;
				endcase

				if (spr_done)
				begin
					if (spr == idx_w'(num_sprites - 1))
					begin
						state <= s_idle;	// line complete
						busy <= 1'b0;
					end
					else
					begin
						spr <= spr + 1'b1;
						state <= s_attr;
					end
				end
			end
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		if (state == s_attr)
			sa <= attr;
		if (state == s_check)
			line_addr <= sa.base + 16'(row) * 16'(sa.width_words);
		if ((state == s_wait) && mem_ack)
			word <= mem_data;
		p1_x <= xpos[8:0];
		p1_tc <= (sa.mode == spu_pkg::true_color);
		p1_byte <= word.tc[~pix[0]];
	end

	a_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req && !mem_ack |=> $stable(mem_addr));
	a_ack_req: assert property (@(posedge clk) disable iff (!arst_n)
		mem_ack |-> mem_req);

endmodule

/* hdl/spu_pkg.sv */
package spu_pkg;

	// --------------------
	// sizes
	// --------------------
	localparam int line_w = 256;		// pixels per line
	localparam int pal_entries = 256;	// 16 banks of 16 colours

	// colour mode of a sprite
	typedef enum logic [1:0] {
		off           = 2'd0,
		four_color    = 2'd1,
		sixteen_color = 2'd2,
		true_color    = 2'd3
	} mode_e;

	// palette entry, line buffer entry, true colour byte
	typedef struct packed {
		logic       opaque;	// 0 = transparent
		logic [6:0] rgb;
	} color_t;

	// one sprite, low half at word 2i, high half at word 2i+1
	typedef struct packed {
		logic [8:0]  x;
		logic [8:0]  y;
		logic [6:0]  height;		// in lines
		mode_e       mode;
		logic        flip_x;
		logic        flip_y;
		logic [15:0] base;		// word address of row 0
		logic [5:0]  width_words;	// words per sprite row
		logic [3:0]  pal;		// palette bank
		logic [8:0]  pad;
	} sprite_attr_t;

	// one memory word, leftmost pixel in the top field
	typedef union packed {
		logic [7:0][1:0] c4;	// 8 pixels of 2 bits
		logic [3:0][3:0] c16;	// 4 pixels of 4 bits
		color_t [1:0]    tc;	// 2 raw bytes
	} mem_word_u;

	// log2 of pixels per word
	function automatic logic [1:0] ppw_log2(input mode_e m);
		case (m)
			four_color:    return 2'd3;	// 8 px
			sixteen_color: return 2'd2;	// 4 px
			default:       return 2'd1;	// 2 px, true colour
		endcase
	endfunction

endpackage

/* hdl/spu_regs.sv */
module spu_regs #(
	parameter int num_sprites = 16
) (
	input  logic                              clk,
	input  logic                              arst_n,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [11:0]                       paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	input  logic [$clog2(num_sprites)-1:0]    attr_idx,
	output spu_pkg::sprite_attr_t             attr,
	input  logic [7:0]                        pal_addr,
	output spu_pkg::color_t                   pal_data
);
	localparam int idx_w = $clog2(num_sprites);

	logic [31:0] attr_lo [num_sprites];	// words 2i
	logic [31:0] attr_hi [num_sprites];	// words 2i+1
	spu_pkg::color_t pal_mem [spu_pkg::pal_entries];

	logic [4:0] spr_sel;	// byte addr bits 7:3, up to 32 sprites
	logic attr_hit;
	logic pal_hit;
	logic wr_acc;

	// --------------------
	// address decode
	// --------------------
	assign spr_sel  = paddr[7:3];
	assign attr_hit = (paddr[11:8] == 4'h0) && (32'(spr_sel) < num_sprites);	// 0x000..0x0ff
	assign pal_hit  = (paddr[11:10] == 2'b01);					// 0x400..0x7ff
	assign wr_acc   = psel && penable && pwrite;	// access phase
	assign pready   = 1'b1;				// no wait states

	always_ff @(posedge clk)
	begin
		if (wr_acc && attr_hit)
		begin
			if (paddr[2])
				attr_hi[spr_sel[idx_w-1:0]] <= pwdata;
			else
				attr_lo[spr_sel[idx_w-1:0]] <= pwdata;
		end
		if (wr_acc && pal_hit)
			pal_mem[paddr[9:2]] <= spu_pkg::color_t'(pwdata[7:0]);	// one byte per word
		pal_data <= pal_mem[pal_addr];	// engine port, sync read
	end

	// readback of the stored value
	always_comb
	begin
		prdata = '0;
		if (attr_hit)
			prdata = paddr[2] ? attr_hi[spr_sel[idx_w-1:0]] : attr_lo[spr_sel[idx_w-1:0]];
		else if (pal_hit)
			prdata = {24'h0, pal_mem[paddr[9:2]]};
	end

	assign attr = {attr_hi[attr_idx], attr_lo[attr_idx]};	// combinational to engine

	// address held from setup into access
	a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
		psel && !penable |=> $stable(paddr));

endmodule

/* hdl/spu_top.sv */
module spu_top #(
	parameter int num_sprites = 16
) (
	input  logic            clk,
	input  logic            arst_n,
	// apb
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  logic [11:0]     paddr,
	input  logic [31:0]     pwdata,
	output logic [31:0]     prdata,
	output logic            pready,
	// video timing
	input  logic            frame_start,
	input  logic            line_start,
	// sprite memory
	output logic            mem_req,
	output logic [15:0]     mem_addr,
	input  logic            mem_ack,
	input  logic [15:0]     mem_data,
	// display
	input  logic            pix_en,
	output logic            pix_valid,
	output spu_pkg::color_t pix_color,
	output logic            busy
);
	logic [$clog2(num_sprites)-1:0] attr_idx;
	spu_pkg::sprite_attr_t attr;
	logic [7:0] pal_addr;
	spu_pkg::color_t pal_data;
	logic wr_en;
	logic [8:0] wr_x;
	spu_pkg::color_t wr_pix;

	spu_regs #(.num_sprites(num_sprites)) i_regs (
		.clk, .arst_n,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.attr_idx, .attr, .pal_addr, .pal_data
	);

	sprite_engine #(.num_sprites(num_sprites)) i_engine (
		.clk, .arst_n, .frame_start, .line_start,
		.attr_idx, .attr, .pal_addr, .pal_data,
		.mem_req, .mem_addr, .mem_ack, .mem_data,
		.wr_en, .wr_x, .wr_pix, .busy
	);

	line_buffer i_lbuf (
		.clk, .arst_n, .line_start,
		.wr_en, .wr_x, .wr_pix,
		.pix_en, .pix_valid, .pix_color
	);

endmodule

/* src.f */
+incdir+tests
hdl/spu_pkg.sv
hdl/spu_regs.sv
hdl/sprite_engine.sv
hdl/line_buffer.sv
hdl/spu_top.sv
tests/tb_spu.sv

/* tests/spu_ref.svh */
`ifndef SPU_REF_SVH
`define SPU_REF_SVH

// --------------------
// shadow state
// --------------------
spu_pkg::sprite_attr_t sh_attr [num_sprites];	// what the regs hold
logic [7:0] sh_pal [256];
logic [15:0] sh_mem [65536];			// sprite memory, served by the responder

// field p of a word, counted from the left
function automatic int field_of(input logic [15:0] w, input int bits, input int p);
	return int'(w >> (16 - bits * (p + 1))) & ((1 << bits) - 1);
endfunction

// expected colour at pixel px of line ln, top sprite searched first
function automatic logic [7:0] ref_pixel(input int ln, input int px);
	spu_pkg::sprite_attr_t a;
	int s;
	int ppw;
	int ww;
	int tw;
	int dy;
	int row;
	int k;
	int v;
	logic [15:0] w;
	logic [7:0] c;
	for (s = num_sprites - 1; s >= 0; s--)
	begin
		a = sh_attr[s];
		ww = int'(a.width_words);
		dy = ln - int'(a.y);
		case (a.mode)
			spu_pkg::four_color:    ppw = 8;
			spu_pkg::sixteen_color: ppw = 4;
			spu_pkg::true_color:    ppw = 2;
			default:                ppw = 0;	// off
		endcase
		if (ppw == 0 || ww == 0 || dy < 0 || dy >= int'(a.height))
			continue;
		tw = ww * ppw;
		row = a.flip_y ? int'(a.height) - 1 - dy : dy;
		k = a.flip_x ? int'(a.x) + tw - 1 - px : px - int'(a.x);	// pixel within row
		if (k < 0 || k >= tw)
			continue;
		w = sh_mem[16'(int'(a.base) + row * ww + k / ppw)];
		v = field_of(w, 16 / ppw, k % ppw);
		c = (ppw == 2) ? 8'(v) : sh_pal[8'(int'(a.pal) * 16 + v)];
		if (c[7])
			return c;	// opaque, hides what is below
	end
	return 8'h00;	// untouched entry reads as cleared
endfunction

`endif

/* tests/tb_spu.sv */
module tb_spu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_sprites = 16;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic frame_start;
	logic line_start;
	logic mem_req;
	logic [15:0] mem_addr;
	logic mem_ack;
	logic [15:0] mem_data;
	logic pix_en;
	logic pix_valid;
	spu_pkg::color_t pix_color;
	logic busy;

	int err_cnt;
	int to_cnt;
	int lat_tab [64];	// ack latencies drawn up front
	int lat_idx;
	int exp_q [$];		// line, x and colour of each strobed pixel
	logic [7:0] pend [256];	// built line shown on the next one
	int pend_line;
	int cur_line;
	string test_name;
	string pend_name;
	string shown_name;

	`include "spu_ref.svh"

	spu_top #(.num_sprites(num_sprites)) i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory responder acks after 0..3 cycles
	initial
	begin
		mem_ack = 1'b0;
		mem_data = '0;
		forever
		begin
			@(negedge clk);
			if (mem_req)
			begin
				repeat (lat_tab[lat_idx]) @(negedge clk);
				lat_idx = (lat_idx + 1) % 64;
				mem_ack = 1'b1;
				mem_data = sh_mem[mem_addr];
				@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	// display compare one cycle behind pix_en
	always @(negedge clk)
	begin
		int e;
		if (pix_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("display gave a pixel that was never strobed");
				err_cnt++;
			end
			else
			begin
				e = exp_q.pop_front();
				if (pix_color !== 8'(e))
				begin
					$display("FAIL %s line %0d x %0d: expected %02h actual %02h",
						shown_name, e >> 16, (e >> 8) & 255, 8'(e), pix_color);
					err_cnt++;
				end
			end
		end
	end

	// --------------------
	// helpers
	// --------------------
	task automatic end_run();
		$display("errors: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		psel = 1'b1;	// setup
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;	// access phase where the write lands
		if (!pready)
		begin
			$display("APB slave was not ready in the access phase");
			err_cnt++;
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_check(input logic [11:0] addr, input logic [31:0] exp);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		if (prdata !== exp)
		begin
			$display("FAIL %s readback %03h: expected %08h actual %08h",
				test_name, addr, exp, prdata);
			err_cnt++;
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_sprite(input int idx, input spu_pkg::sprite_attr_t a);
		sh_attr[idx] = a;
		apb_write(12'(idx * 8), a[31:0]);	// low half
		apb_write(12'(idx * 8 + 4), a[63:32]);
	endtask

	task automatic write_palette(input int idx, input logic [7:0] c);
		sh_pal[idx] = c;
		apb_write(12'(1024 + idx * 4), {24'h0, c});
	endtask

	task automatic clear_sprites();
		int i;
		for (i = 0; i < num_sprites; i++)
			write_sprite(i, '0);
	endtask

	function automatic spu_pkg::sprite_attr_t pack_sprite(input int x, input int y, input int h,
		input spu_pkg::mode_e m, input logic fx, input logic fy, input int base,
		input int ww, input int pal);
		spu_pkg::sprite_attr_t a;
		a = '0;
		a.x = 9'(x);
		a.y = 9'(y);
		a.height = 7'(h);
		a.mode = m;
		a.flip_x = fx;
		a.flip_y = fy;
		a.base = 16'(base);
		a.width_words = 6'(ww);
		a.pal = 4'(pal);
		return a;
	endfunction

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 20000)
		begin
			@(negedge clk);
			n++;
		end
		if (busy)
		begin
			$display("busy stayed high for %0d cycles in %s", n, test_name);
			to_cnt++;
		end
	endtask

	// one line period shows the last build and builds the next
	task automatic run_line(input logic new_frame);
		int x;
		int n;
		if (to_cnt != 0)
			return;	// a stuck line ends the sequence
		line_start = 1'b1;
		frame_start = new_frame;
		@(negedge clk);
		line_start = 1'b0;
		frame_start = 1'b0;
		cur_line = new_frame ? 0 : cur_line + 1;
		shown_name = pend_name;
		for (x = 0; x < 256; x++)
			exp_q.push_back((pend_line << 16) | (x << 8) | int'(pend[x]));
		for (x = 0; x < 256; x++)
		begin
			pix_en = 1'b1;
			@(negedge clk);
		end
		pix_en = 1'b0;
		n = 0;
		while (exp_q.size() != 0 && n < 8)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d strobed pixels never came back in %s", exp_q.size(), shown_name);
			to_cnt++;
			return;
		end
		wait_idle();
		if (to_cnt != 0)
			return;
		for (x = 0; x < 256; x++)
			pend[x] = ref_pixel(cur_line, x);
		pend_line = cur_line;
		pend_name = test_name;
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial
	begin
		spu_pkg::sprite_attr_t a;
		int i;
		void'($urandom(4396));
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		frame_start = 1'b0;
		line_start = 1'b0;
		pix_en = 1'b0;
		for (i = 0; i < 64; i++)
			lat_tab[i] = int'($urandom_range(0, 3));
		for (i = 0; i < 65536; i++)
			sh_mem[i] = 16'(i * 40503);	// odd multiplier keeps every address distinct
		for (i = 0; i < 256; i++)
			pend[i] = 8'h00;	// reset clears both halves
		pend_line = 0;
		pend_name = "reset";
		test_name = "reset";

		repeat (8) @(negedge clk);
		if ({mem_req, busy, pix_valid} !== 3'b000)
		begin
			$display("FAIL %s req/busy/valid: expected 000 actual %b", test_name,
				{mem_req, busy, pix_valid});
			err_cnt++;
		end
		arst_n = 1'b1;
		@(negedge clk);
		if (busy !== 1'b1)
		begin
			$display("FAIL %s busy during clear: expected 1 actual %b", test_name, busy);
			err_cnt++;
		end
		wait_idle();

		// no sprites with random palette and register readback
		test_name = "empty";
		clear_sprites();
		for (i = 0; i < 256; i++)
			write_palette(i, 8'($urandom));
		a = pack_sprite(300, 400, 9, spu_pkg::off, 1'b1, 1'b0, 16'hbeef, 13, 6);
		write_sprite(1, a);
		apb_check(12'h008, a[31:0]);
		apb_check(12'h00c, a[63:32]);
		apb_check(12'h494, {24'h0, sh_pal[37]});
		run_line(1'b1);
		run_line(1'b0);

		test_name = "single_16c";
		clear_sprites();
		write_sprite(3, pack_sprite(20, 3, 4, spu_pkg::sixteen_color, 1'b0, 1'b0, 'h100, 3, 5));
		run_line(1'b1);
		repeat (9) run_line(1'b0);	// lines above, on and below

		test_name = "flip_x_tc";
		clear_sprites();
		write_sprite(0, pack_sprite(30, 0, 2, spu_pkg::four_color, 1'b1, 1'b0, 'h200, 2, 2));
		write_sprite(1, pack_sprite(36, 0, 2, spu_pkg::true_color, 1'b0, 1'b0, 'h300, 5, 0));
		run_line(1'b1);
		repeat (2) run_line(1'b0);

		test_name = "overlap_flip_y";
		clear_sprites();
		write_sprite(2, pack_sprite(100, 1, 5, spu_pkg::sixteen_color, 1'b0, 1'b1, 'h400, 2, 7));
		write_sprite(5, pack_sprite(104, 2, 3, spu_pkg::four_color, 1'b0, 1'b1, 'h500, 1, 9));
		write_sprite(6, pack_sprite(250, 0, 6, spu_pkg::true_color, 1'b1, 1'b0, 'h600, 6, 0));
		run_line(1'b1);
		repeat (7) run_line(1'b0);

		// two frames of 10 lines each
		test_name = "random";
		for (i = 0; i < 4096; i++)
			sh_mem[i] = 16'($urandom);
		for (i = 0; i < 256; i++)
			write_palette(i, 8'($urandom));
		for (i = 0; i < num_sprites; i++)
		begin
			a = pack_sprite(int'($urandom_range(0, 300)), int'($urandom_range(0, 9)),
				int'($urandom_range(1, 8)), spu_pkg::mode_e'(2'($urandom_range(0, 3))),
				1'($urandom), 1'($urandom), int'($urandom_range(0, 3000)),
				int'($urandom_range(1, 6)), int'($urandom_range(0, 15)));
			write_sprite(i, a);
		end
		run_line(1'b1);
		repeat (9) run_line(1'b0);
		run_line(1'b1);	// new frame restarts at line 0
		repeat (9) run_line(1'b0);
		run_line(1'b0);	// shows the last one

		end_run();
	end

endmodule
